// File: rtl/video_pkg.sv
`default_nettype none

package video_pkg;

   ////////////////////
   // Line and frame timing

   // One dot per clock, 456 dots per line
   localparam logic [8:0] DOTS_PER_LINE   = 9'd456;
   localparam logic [7:0] LINES_PER_FRAME = 8'd154;
   // Mode 2 then mode 3, the rest of the line is mode 0
   localparam logic [8:0] OAM_SCAN_DOTS   = 9'd80;
   localparam logic [8:0] TRANSFER_DOTS   = 9'd172;
   localparam logic [7:0] VISIBLE_LINES   = 8'd144;
   localparam logic [7:0] SCREEN_WIDTH    = 8'd160;
   localparam logic [8:0] HSYNC_START_DOT = 9'd412;

   // STAT mode codes
   localparam logic [1:0] MODE_HBLANK   = 2'd0;
   localparam logic [1:0] MODE_VBLANK   = 2'd1;
   localparam logic [1:0] MODE_OAM      = 2'd2;
   localparam logic [1:0] MODE_TRANSFER = 2'd3;

   ////////////////////
   // CPU register map
   localparam logic [15:0] ADDR_LCDC = 16'hFF40;
   localparam logic [15:0] ADDR_STAT = 16'hFF41;
   localparam logic [15:0] ADDR_SCY  = 16'hFF42;
   localparam logic [15:0] ADDR_SCX  = 16'hFF43;
   localparam logic [15:0] ADDR_LY   = 16'hFF44;
   localparam logic [15:0] ADDR_LYC  = 16'hFF45;
   localparam logic [15:0] ADDR_BGP  = 16'hFF47;

   ////////////////////
   // Video RAM layout
   localparam logic [15:0] VRAM_BASE = 16'h8000;
   localparam logic [15:0] VRAM_END  = 16'hA000;
   localparam int VRAM_ADDR_BITS = 13;

   typedef logic [VRAM_ADDR_BITS-1:0] vram_addr_t;

   // Tile maps, 32 x 32 entries each
   localparam vram_addr_t MAP0_BASE = 13'h1800;
   localparam vram_addr_t MAP1_BASE = 13'h1C00;
   // Tile data, 16 bytes per tile
   localparam vram_addr_t TILE_DATA_UNSIGNED_BASE = 13'h0000;
   localparam vram_addr_t TILE_DATA_SIGNED_BASE   = 13'h1000;

   localparam logic [7:0] BGP_RESET = 8'hFC;
   localparam logic [7:0] OPEN_BUS  = 8'hFF;

   // Background fetch states
   localparam logic [2:0] FETCH_IDLE      = 3'd0;
   localparam logic [2:0] FETCH_MAP_READ  = 3'd1;
   localparam logic [2:0] FETCH_MAP_WAIT  = 3'd2;
   localparam logic [2:0] FETCH_DATA_READ = 3'd3;
   localparam logic [2:0] FETCH_PIXEL_OUT = 3'd4;

   // Map entry, unsigned with LCDC bit 4 set, else signed around 1000h
   typedef union packed {
      logic        [7:0] unsigned_index;
      logic signed [7:0] signed_index;
   } tile_index_t;

endpackage

`default_nettype wire

// File: rtl/lcd_registers.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_registers (
   input  wire                    clock,
   input  wire                    reset,
   input  wire                    mem_enable,
   input  wire                    rd_n,
   input  wire                    wr_n,
   input  wire             [15:0] addr,
   input  wire              [7:0] wdata,
   input  wire              [7:0] line_count,
   input  wire              [1:0] mode,
   input  wire              [7:0] cpu_vram_rdata,
   output logic             [7:0] rdata,
   output video_pkg::vram_addr_t  cpu_vram_addr,
   output logic                   cpu_vram_write,
   output logic                   cpu_vram_select,
   output logic                   lcd_on,
   output logic                   map_select,
   output logic                   data_select,
   output logic                   bg_enable,
   output logic             [7:0] scx,
   output logic             [7:0] scy,
   output logic             [7:0] lyc,
   output logic             [7:0] bgp,
   output logic             [3:0] stat_enables
);
   import video_pkg::*;

   logic       read_cycle;
   logic       write_cycle;
   logic       in_vram;
   logic [7:0] lcdc;
   logic [4:0] stat_upper;
   logic [7:0] stat;
   logic [7:0] reg_rdata;
   logic       vram_read;

   assign read_cycle  = mem_enable && !rd_n;
   assign write_cycle = mem_enable && !wr_n;
   assign in_vram     = (addr >= VRAM_BASE) && (addr < VRAM_END);

   // Video RAM window, forwarded to the RAM arbiter
   assign cpu_vram_addr   = vram_addr_t'(addr - VRAM_BASE);
   assign cpu_vram_select = in_vram && (read_cycle || write_cycle);
   assign cpu_vram_write  = in_vram && write_cycle;

   // LCDC fields
   assign lcd_on      = lcdc[7];
   assign data_select = lcdc[4];
   assign map_select  = lcdc[3];
   assign bg_enable   = lcdc[0];

   // STAT bits 6..3 are the interrupt enables
   assign stat_enables = stat_upper[3:0];
   // Upper bits as written, then coincidence flag and live mode
   assign stat = {stat_upper, line_count == lyc, mode};

   always_ff @(posedge clock) begin
      if (reset) begin
         lcdc       <= 8'h00;
         stat_upper <= 5'd0;
         scy        <= 8'h00;
         scx        <= 8'h00;
         lyc        <= 8'h00;
         bgp        <= BGP_RESET;
         vram_read  <= 1'b0;
      end else begin
         if (write_cycle) begin
            // LY is read only, a write to it falls to default
            case (addr)
               ADDR_LCDC: lcdc       <= wdata;
               ADDR_STAT: stat_upper <= wdata[7:3];
               ADDR_SCY:  scy        <= wdata;
               ADDR_SCX:  scx        <= wdata;
               ADDR_LYC:  lyc        <= wdata;
               ADDR_BGP:  bgp        <= wdata;
               default:   ;
            endcase
         end
         // Remember where the last read went
         if (read_cycle)
            vram_read <= in_vram;
      end
   end

   ////////////////////
   // Read data
   always_ff @(posedge clock) begin
      if (read_cycle) begin
         case (addr)
            ADDR_LCDC: reg_rdata <= lcdc;
            ADDR_STAT: reg_rdata <= stat;
            ADDR_SCY:  reg_rdata <= scy;
            ADDR_SCX:  reg_rdata <= scx;
            ADDR_LY:   reg_rdata <= line_count;
            ADDR_LYC:  reg_rdata <= lyc;
            ADDR_BGP:  reg_rdata <= bgp;
            default:   reg_rdata <= OPEN_BUS;
         endcase
      end
   end

   // RAM data is registered inside video_ram with the same latency
   assign rdata = vram_read ? cpu_vram_rdata : reg_rdata;

   // Bus strobes are exclusive
   assert property (@(posedge clock) disable iff (reset) mem_enable |-> (rd_n || wr_n))
      else $error("rd_n and wr_n low together");

endmodule

`default_nettype wire

// File: rtl/lcd_timing.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_timing (
   input  wire        clock,
   input  wire        reset,
   input  wire        lcd_on,
   input  wire  [7:0] lyc,
   input  wire  [3:0] stat_enables,
   input  wire        int_vblank_ack,
   input  wire        int_lcdc_ack,
   output logic [7:0] line_count,
   output logic [1:0] mode,
   output logic       transfer_start,
   output logic       hsync,
   output logic       vsync,
   output logic       int_vblank_req,
   output logic       int_lcdc_req
);
   import video_pkg::*;

   logic [8:0] dot_count;
   logic [1:0] next_mode;
   logic       mode_entry;
   logic       vblank_event;
   logic       lyc_event;
   logic       stat_event;

   ////////////////////
   // Dot and line counters
   always_ff @(posedge clock) begin
      if (reset || !lcd_on) begin
         dot_count  <= '0;
         line_count <= '0;
      end else if (dot_count == DOTS_PER_LINE - 9'd1) begin
         dot_count <= '0;
         if (line_count == LINES_PER_FRAME - 8'd1)
            line_count <= '0;
         else
            line_count <= line_count + 8'd1;
      end else begin
         dot_count <= dot_count + 9'd1;
      end
   end

   // Mode decode, registered one clock behind the counters
   always_comb begin
      if (line_count >= VISIBLE_LINES)
         next_mode = MODE_VBLANK;
      else if (dot_count < OAM_SCAN_DOTS)
         next_mode = MODE_OAM;
      else if (dot_count < OAM_SCAN_DOTS + TRANSFER_DOTS)
         next_mode = MODE_TRANSFER;
      else
         next_mode = MODE_HBLANK;
   end

   ////////////////////
   // Interrupt events
   assign mode_entry   = lcd_on && (next_mode != mode);
   assign vblank_event = mode_entry && (next_mode == MODE_VBLANK);
   // Modes 0..2 line up with enable bits 0..2; bit 3 is LYC
   assign stat_event   = (mode_entry && (next_mode != MODE_TRANSFER) &&
                          stat_enables[next_mode]) || lyc_event;
   // Once per line, at dot 0
   assign lyc_event    = lcd_on && (dot_count == 9'd0) && (line_count == lyc) &&
                         stat_enables[3];

   always_ff @(posedge clock) begin
      if (reset) begin
         mode           <= MODE_HBLANK;
         transfer_start <= 1'b0;
         hsync          <= 1'b0;
         vsync          <= 1'b0;
         int_vblank_req <= 1'b0;
         int_lcdc_req   <= 1'b0;
      end else begin
         mode           <= lcd_on ? next_mode : MODE_HBLANK;
         // Same edge that moves mode to 3
         transfer_start <= mode_entry && (next_mode == MODE_TRANSFER);
         hsync          <= lcd_on && (dot_count > HSYNC_START_DOT);
         vsync          <= lcd_on && (line_count >= VISIBLE_LINES);
         // New event wins over acknowledge
         int_vblank_req <= vblank_event || (int_vblank_req && !int_vblank_ack);
         int_lcdc_req   <= stat_event || (int_lcdc_req && !int_lcdc_ack);
      end
   end

   assert property (@(posedge clock) disable iff (reset) line_count < LINES_PER_FRAME)
      else $error("line_count out of range");

endmodule

`default_nettype wire

// File: rtl/video_ram.sv
`timescale 1ns/1ps
`default_nettype none

module video_ram (
   input  wire                        clock,
   input  wire video_pkg::vram_addr_t cpu_vram_addr,
   input  wire                        cpu_vram_write,
   input  wire                        cpu_vram_select,
   input  wire                  [7:0] wdata,
   input  wire                  [1:0] mode,
   input  wire                        render_busy,
   input  wire video_pkg::vram_addr_t render_addr_a,
   input  wire video_pkg::vram_addr_t render_addr_b,
   output logic                 [7:0] cpu_vram_rdata,
   output logic                 [7:0] render_rdata_a,
   output logic                 [7:0] render_rdata_b
);
   import video_pkg::*;

   logic [7:0] mem [0:(1 << VRAM_ADDR_BITS) - 1];
   logic       locked;
   vram_addr_t addr_a;
   logic       cpu_read;
   logic       cpu_blocked;
   logic [7:0] cpu_hold;

   // Renderer owns port A for all of mode 3 and until its pass ends
   assign locked = (mode == MODE_TRANSFER) || render_busy;
   assign addr_a = locked ? render_addr_a : cpu_vram_addr;

   always_ff @(posedge clock) begin
      // CPU writes dropped while locked
      if (cpu_vram_write && !locked)
         mem[cpu_vram_addr] <= wdata;
      render_rdata_a <= mem[addr_a];
      // Port B, renderer only
      render_rdata_b <= mem[render_addr_b];
      cpu_read    <= cpu_vram_select && !cpu_vram_write;
      cpu_blocked <= locked;
      // Keep CPU data until the next CPU read
      if (cpu_read)
         cpu_hold <= cpu_vram_rdata;
   end

   assign cpu_vram_rdata = !cpu_read   ? cpu_hold :
                           cpu_blocked ? OPEN_BUS : render_rdata_a;

endmodule

`default_nettype wire

// File: rtl/bg_fetch_control.sv
`timescale 1ns/1ps
`default_nettype none

module bg_fetch_control (
   input  wire        clock,
   input  wire        reset,
   input  wire        transfer_start,
   input  wire  [7:0] scx,
   output logic       render_busy,
   output logic       fetch_data,
   output logic       load_row,
   output logic       shift_pixel,
   output logic [2:0] fine_x,
   output logic [7:0] pixel_column
);
   import video_pkg::*;

   logic [2:0] state;
   logic       row_loaded;
   logic [7:0] scroll_x;

   // Scrolled column of the current output pixel
   assign scroll_x = scx + pixel_column;
   assign fine_x   = scroll_x[2:0];

   ////////////////////
   // Outputs from state
   assign render_busy = (state != FETCH_IDLE);
   assign fetch_data  = (state == FETCH_DATA_READ);
   // First pixel-out cycle latches the row, the rest shift
   assign load_row    = (state == FETCH_PIXEL_OUT) && !row_loaded;
   assign shift_pixel = (state == FETCH_PIXEL_OUT) && row_loaded;

   // Per tile: map read, map wait, data read, row load, then pixels
   always_ff @(posedge clock) begin
      if (reset) begin
         state        <= FETCH_IDLE;
         row_loaded   <= 1'b0;
         pixel_column <= 8'd0;
      end else begin
         case (state)
            FETCH_IDLE: begin
               if (transfer_start) begin
                  pixel_column <= 8'd0;
                  state        <= FETCH_MAP_READ;
               end
            end
            FETCH_MAP_READ:
               state <= FETCH_MAP_WAIT;
            // Map entry appears on port A here
            FETCH_MAP_WAIT:
               state <= FETCH_DATA_READ;
            FETCH_DATA_READ: begin
               row_loaded <= 1'b0;
               state      <= FETCH_PIXEL_OUT;
            end
            FETCH_PIXEL_OUT: begin
               row_loaded <= 1'b1;
               if (row_loaded) begin
                  pixel_column <= pixel_column + 8'd1;
                  // Line done, or next pixel lies in a new tile
                  if (pixel_column == SCREEN_WIDTH - 8'd1)
                     state <= FETCH_IDLE;
                  else if (fine_x == 3'd7)
                     state <= FETCH_MAP_READ;
               end
            end
            default:
               state <= FETCH_IDLE;
         endcase
      end
   end

   // A pass always ends inside its own line
   assert property (@(posedge clock) disable iff (reset) transfer_start |-> !render_busy)
      else $error("transfer_start during a fetch pass");

endmodule

`default_nettype wire

// File: rtl/tile_address.sv
`timescale 1ns/1ps
`default_nettype none

module tile_address (
   input  wire                  [7:0] scx,
   input  wire                  [7:0] scy,
   input  wire                  [7:0] line_count,
   input  wire                  [7:0] pixel_column,
   input  wire                        fetch_data,
   input  wire                        map_select,
   input  wire                        data_select,
   input  wire                  [7:0] render_rdata_a,
   output video_pkg::vram_addr_t      render_addr_a,
   output video_pkg::vram_addr_t      render_addr_b
);
   import video_pkg::*;

   logic        [7:0] scroll_x;
   logic        [7:0] scroll_y;
   tile_index_t       index;
   logic signed [12:0] signed_offset;
   vram_addr_t        map_addr;
   vram_addr_t        tile_base;
   vram_addr_t        row_addr;

   assign scroll_x = scx + pixel_column;
   assign scroll_y = scy + line_count;

   // Map entry, 32 tiles per map row
   assign map_addr = (map_select ? MAP1_BASE : MAP0_BASE) +
                     vram_addr_t'({scroll_y[7:3], scroll_x[7:3]});

   // Index byte from the map read
   assign index         = render_rdata_a;
   assign signed_offset = 13'(index.signed_index) <<< 4;
   assign tile_base     = data_select ?
                          TILE_DATA_UNSIGNED_BASE + vram_addr_t'({index.unsigned_index, 4'h0}) :
                          TILE_DATA_SIGNED_BASE + vram_addr_t'(signed_offset);

   // Two bytes per tile row, low plane first
   assign row_addr      = tile_base + vram_addr_t'({scroll_y[2:0], 1'b0});
   assign render_addr_a = fetch_data ? row_addr : map_addr;
   assign render_addr_b = row_addr + 13'd1;

endmodule

`default_nettype wire

// File: rtl/pixel_shade.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_shade (
   input  wire        clock,
   input  wire        reset,
   input  wire        load_row,
   input  wire        shift_pixel,
   input  wire  [2:0] fine_x,
   input  wire  [7:0] render_rdata_a,
   input  wire  [7:0] render_rdata_b,
   input  wire        bg_enable,
   input  wire  [7:0] bgp,
   output logic [1:0] pixel_data,
   output logic       pixel_we
);
   logic [7:0] row_lo;
   logic [7:0] row_hi;
   logic [1:0] color;

   // Leftmost pixel in bit 7, color 0 with background off
   assign color = bg_enable ? {row_hi[3'd7 - fine_x], row_lo[3'd7 - fine_x]} : 2'b00;

   always_ff @(posedge clock) begin
      if (load_row) begin
         row_lo <= render_rdata_a;
         row_hi <= render_rdata_b;
      end
      // Shade through BGP, two bits per color
      if (shift_pixel)
         pixel_data <= bgp[{color, 1'b0} +: 2];
   end

   always_ff @(posedge clock) begin
      if (reset)
         pixel_we <= 1'b0;
      else
         pixel_we <= shift_pixel;
   end

endmodule

`default_nettype wire

// File: rtl/video_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_top (
   input  wire        clock,
   input  wire        reset,
   input  wire        mem_enable,
   input  wire        rd_n,
   input  wire        wr_n,
   input  wire [15:0] addr,
   input  wire  [7:0] wdata,
   output logic [7:0] rdata,
   input  wire        int_vblank_ack,
   input  wire        int_lcdc_ack,
   output logic       int_vblank_req,
   output logic       int_lcdc_req,
   output logic       hsync,
   output logic       vsync,
   output logic [7:0] line_count,
   output logic [1:0] pixel_data,
   output logic       pixel_we
);
   import video_pkg::*;

   // Register fields
   logic       lcd_on, map_select, data_select, bg_enable;
   logic [7:0] scx, scy, lyc, bgp;
   logic [3:0] stat_enables;
   logic [1:0] mode;
   logic       transfer_start;

   // CPU side of the RAM
   vram_addr_t cpu_vram_addr;
   logic       cpu_vram_write, cpu_vram_select;
   logic [7:0] cpu_vram_rdata;

   // Renderer
   logic       render_busy, fetch_data, load_row, shift_pixel;
   logic [2:0] fine_x;
   logic [7:0] pixel_column;
   vram_addr_t render_addr_a, render_addr_b;
   logic [7:0] render_rdata_a, render_rdata_b;

   lcd_registers lcd_registers_inst (
      .clock, .reset, .mem_enable, .rd_n, .wr_n, .addr, .wdata,
      .line_count, .mode, .cpu_vram_rdata, .rdata,
      .cpu_vram_addr, .cpu_vram_write, .cpu_vram_select,
      .lcd_on, .map_select, .data_select, .bg_enable,
      .scx, .scy, .lyc, .bgp, .stat_enables
   );

   lcd_timing lcd_timing_inst (
      .clock, .reset, .lcd_on, .lyc, .stat_enables,
      .int_vblank_ack, .int_lcdc_ack,
      .line_count, .mode, .transfer_start, .hsync, .vsync,
      .int_vblank_req, .int_lcdc_req
   );

   video_ram video_ram_inst (
      .clock, .cpu_vram_addr, .cpu_vram_write, .cpu_vram_select, .wdata,
      .mode, .render_busy, .render_addr_a, .render_addr_b,
      .cpu_vram_rdata, .render_rdata_a, .render_rdata_b
   );

   bg_fetch_control bg_fetch_control_inst (
      .clock, .reset, .transfer_start, .scx,
      .render_busy, .fetch_data, .load_row, .shift_pixel, .fine_x, .pixel_column
   );

   tile_address tile_address_inst (
      .scx, .scy, .line_count, .pixel_column, .fetch_data,
      .map_select, .data_select, .render_rdata_a,
      .render_addr_a, .render_addr_b
   );

   pixel_shade pixel_shade_inst (
      .clock, .reset, .load_row, .shift_pixel, .fine_x,
      .render_rdata_a, .render_rdata_b, .bg_enable, .bgp,
      .pixel_data, .pixel_we
   );

endmodule

`default_nettype wire

// File: tb/video_tb.sv
`timescale 1ns/1ps
`default_nettype none

module video_tb;
   import video_pkg::*;

   localparam int FRAME_CLOCKS = 456 * 154;
   localparam int ROWS = 5;

   logic        clock;
   logic        reset;
   logic        mem_enable;
   logic        rd_n;
   logic        wr_n;
   logic [15:0] addr;
   logic  [7:0] wdata;
   logic  [7:0] rdata;
   logic        int_vblank_ack;
   logic        int_lcdc_ack;
   logic        int_vblank_req;
   logic        int_lcdc_req;
   logic        hsync;
   logic        vsync;
   logic  [7:0] line_count;
   logic  [1:0] pixel_data;
   logic        pixel_we;

   ////////////////////
   // Pixel test table with one row per captured line
   string      row_name [ROWS] = '{"scroll_unsigned", "scroll_wrap", "signed_map1",
                                   "top_line", "bg_off"};
   logic [7:0] row_lcdc [ROWS] = '{8'h91, 8'h91, 8'h89, 8'h99, 8'h98};
   logic [7:0] row_scx  [ROWS] = '{8'h13, 8'hF5, 8'h06, 8'h00, 8'h3C};
   logic [7:0] row_scy  [ROWS] = '{8'h2C, 8'hE7, 8'h71, 8'h00, 8'h90};
   logic [7:0] row_bgp  [ROWS] = '{8'hE4, 8'h1B, 8'hD2, 8'h27, 8'h93};
   logic [7:0] row_lyc  [ROWS] = '{8'h05, 8'h64, 8'h4D, 8'h00, 8'h8F};
   logic [7:0] row_line [ROWS] = '{8'd5, 8'd100, 8'd77, 8'd0, 8'd143};

   // Copy of everything written to video RAM
   logic  [7:0] vram_copy [0:8191];
   logic [31:0] rng_state;
   logic  [7:0] sampled_line;
   string       current_test;
   int          test_errors;
   int          total_errors;
   int          tests_run;
   int          tests_failed;

   video_top video_top_inst (
      .clock, .reset, .mem_enable, .rd_n, .wr_n, .addr, .wdata, .rdata,
      .int_vblank_ack, .int_lcdc_ack, .int_vblank_req, .int_lcdc_req,
      .hsync, .vsync, .line_count, .pixel_data, .pixel_we
   );

   initial begin
      clock = 1'b0;
      forever #50 clock = ~clock;
   end

   ////////////////////
   // Bookkeeping
   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("** Error: %s, %s: expected %0h, actual %0h",
                  current_test, what, expected, actual);
         test_errors++;
         total_errors++;
      end
   endtask

   task automatic report_timeout(input string what);
      $display("%s: gave up waiting for %s", current_test, what);
      test_errors++;
      total_errors++;
   endtask

   task automatic begin_test(input string name);
      current_test = name;
      test_errors  = 0;
   endtask

   task automatic end_test();
      tests_run++;
      if (test_errors == 0) begin
         $display("%s: passed", current_test);
      end else begin
         tests_failed++;
         $display("%s: failed with %0d errors", current_test, test_errors);
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] state);
      logic [31:0] x;
      x = state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   ////////////////////
   // CPU bus cycles that end on a falling edge
   task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
      @(posedge clock);
      mem_enable <= 1'b1;
      wr_n       <= 1'b0;
      addr       <= a;
      wdata      <= d;
      @(posedge clock);
      mem_enable <= 1'b0;
      wr_n       <= 1'b1;
      @(negedge clock);
   endtask

   task automatic cpu_read(input logic [15:0] a, output logic [7:0] d);
      @(posedge clock);
      mem_enable <= 1'b1;
      rd_n       <= 1'b0;
      addr       <= a;
      // LY as seen by the edge that samples the read
      @(negedge clock);
      sampled_line = line_count;
      @(posedge clock);
      mem_enable <= 1'b0;
      rd_n       <= 1'b1;
      @(negedge clock);
      d = rdata;
   endtask

   task automatic write_and_verify(input logic [15:0] a, input logic [7:0] d,
                                   input string what);
      logic [7:0] data;
      cpu_write(a, d);
      cpu_read(a, data);
      check_value(what, d, data);
   endtask

   // One-cycle acknowledge pulse
   task automatic acknowledge(input logic vblank);
      @(posedge clock);
      if (vblank)
         int_vblank_ack <= 1'b1;
      else
         int_lcdc_ack <= 1'b1;
      @(posedge clock);
      int_vblank_ack <= 1'b0;
      int_lcdc_ack   <= 1'b0;
      @(negedge clock);
   endtask

   task automatic wait_for_line(input logic [7:0] ly, input logic want_equal);
      int cycles;
      cycles = 0;
      while (((line_count == ly) != want_equal) && cycles < 2 * FRAME_CLOCKS) begin
         @(negedge clock);
         cycles++;
      end
      if ((line_count == ly) != want_equal)
         report_timeout($sformatf("a change at line %0d", ly));
   endtask

   // Polls the STAT mode bits
   task automatic wait_for_mode(input logic [1:0] target);
      logic [7:0] data;
      int         polls;
      polls = 0;
      cpu_read(ADDR_STAT, data);
      while (data[1:0] != target && polls < FRAME_CLOCKS) begin
         cpu_read(ADDR_STAT, data);
         polls++;
      end
      if (data[1:0] != target)
         report_timeout($sformatf("mode %0d", target));
   endtask

   ////////////////////
   // Reference model
   function automatic logic [1:0] mode_after(input logic [1:0] prev, input logic [7:0] ly);
      case (prev)
         MODE_OAM:      return MODE_TRANSFER;
         MODE_TRANSFER: return MODE_HBLANK;
         MODE_HBLANK:   return (ly >= VISIBLE_LINES) ? MODE_VBLANK : MODE_OAM;
         default:       return MODE_OAM;
      endcase
   endfunction

   function automatic logic [1:0] expected_pixel(input int r, input int x);
      logic  [7:0] sx;
      logic  [7:0] sy;
      logic  [7:0] lcdc;
      tile_index_t idx;
      int          map_addr;
      int          row_addr;
      int          bit_pos;
      logic  [1:0] color;
      lcdc = row_lcdc[r];
      sx   = row_scx[r] + 8'(x);
      sy   = row_scy[r] + row_line[r];
      // 32 map entries per tile row
      map_addr = int'(lcdc[3] ? MAP1_BASE : MAP0_BASE) + 32 * int'(sy[7:3]) + int'(sx[7:3]);
      idx = vram_copy[map_addr];
      if (lcdc[4])
         row_addr = int'(TILE_DATA_UNSIGNED_BASE) + 16 * int'(idx.unsigned_index);
      else
         row_addr = int'(TILE_DATA_SIGNED_BASE) + 16 * int'(idx.signed_index);
      row_addr = row_addr + 2 * int'(sy[2:0]);
      // Bit 7 is the leftmost pixel
      bit_pos = 7 - int'(sx[2:0]);
      color   = {vram_copy[row_addr + 1][bit_pos], vram_copy[row_addr][bit_pos]};
      if (!lcdc[0])
         color = 2'd0;
      return row_bgp[r][2 * color +: 2];
   endfunction

   ////////////////////
   // Tests
   task automatic register_test();
      logic [7:0] data;
      begin_test("registers");
      cpu_read(ADDR_BGP, data);
      check_value("BGP after reset", 8'hFC, data);
      cpu_read(ADDR_LCDC, data);
      check_value("LCDC after reset", 8'h00, data);
      write_and_verify(ADDR_SCY, 8'h35, "SCY");
      write_and_verify(ADDR_SCX, 8'hA6, "SCX");
      write_and_verify(ADDR_LYC, 8'h2A, "LYC");
      write_and_verify(ADDR_BGP, 8'h1E, "BGP");
      // Display off gives LY 0 and mode 0
      cpu_write(ADDR_STAT, 8'hFF);
      cpu_read(ADDR_STAT, data);
      check_value("STAT upper bits", 8'hF8, data);
      cpu_write(ADDR_STAT, 8'h07);
      cpu_read(ADDR_STAT, data);
      check_value("STAT lower bits", 8'h00, data);
      cpu_write(ADDR_LY, 8'h55);
      cpu_read(ADDR_LY, data);
      check_value("LY write ignored", 8'h00, data);
      cpu_write(ADDR_LYC, 8'h00);
      cpu_read(ADDR_STAT, data);
      check_value("STAT coincidence", 8'h04, data);
      cpu_read(16'hFF46, data);
      check_value("unmapped read", 8'hFF, data);
      end_test();
   endtask

   // Random fill while the display is off
   task automatic preload_vram();
      for (int i = 0; i < 8192; i++) begin
         rng_state    = xorshift32(rng_state);
         vram_copy[i] = rng_state[7:0];
         cpu_write(VRAM_BASE + 16'(i), rng_state[7:0]);
      end
   endtask

   task automatic timing_test();
      logic [7:0] data;
      logic [7:0] prev_line;
      logic [1:0] prev_mode;
      logic [3:0] seen_modes;
      int         changes;
      int         polls;
      int         rises;
      begin_test("timing");
      cpu_write(ADDR_LCDC, 8'h91);
      changes    = 0;
      polls      = 0;
      rises      = 0;
      seen_modes = 4'b0000;
      cpu_read(ADDR_STAT, data);
      prev_mode = data[1:0];
      prev_line = sampled_line;
      // One full frame of line changes up to the wrap to 0
      while (changes < 154 && polls < FRAME_CLOCKS) begin
         cpu_read(ADDR_STAT, data);
         polls++;
         seen_modes[data[1:0]] = 1'b1;
         if (data[1:0] != prev_mode)
            check_value("mode order", mode_after(prev_mode, sampled_line), data[1:0]);
         if (data[1:0] == MODE_VBLANK)
            check_value("mode 1 line", 1'b1, sampled_line >= 144 || sampled_line == 0);
         if (sampled_line != prev_line) begin
            check_value("LY step", (prev_line == 8'd153) ? 8'd0 : prev_line + 8'd1,
                        sampled_line);
            changes++;
         end
         prev_mode = data[1:0];
         prev_line = sampled_line;
         if (int_vblank_req) begin
            rises++;
            acknowledge(1'b1);
            check_value("V-blank request after ack", 1'b0, int_vblank_req);
         end
      end
      if (changes < 154)
         report_timeout("a full frame of lines");
      check_value("modes seen", 4'b1111, seen_modes);
      check_value("V-blank requests per frame", 1, rises);
      end_test();
   endtask

   // hsync width per line and vsync inside and outside V-blank
   task automatic sync_test();
      int hsync_clocks;
      begin_test("sync");
      // Any run of one line's clocks holds exactly one hsync pulse
      hsync_clocks = 0;
      for (int i = 0; i < int'(DOTS_PER_LINE); i++) begin
         if (hsync)
            hsync_clocks++;
         @(negedge clock);
      end
      // High for the dots after HSYNC_START_DOT up to the end of the line
      check_value("hsync clocks per line",
                  int'(DOTS_PER_LINE) - int'(HSYNC_START_DOT) - 1, hsync_clocks);
      wait_for_line(8'd150, 1'b1);
      check_value("vsync in V-blank", 1'b1, vsync);
      wait_for_line(8'd10, 1'b1);
      check_value("vsync on a visible line", 1'b0, vsync);
      end_test();
   endtask

   task automatic pixel_test(input int r);
      int count;
      int cycles;
      begin_test(row_name[r]);
      cpu_write(ADDR_SCX, row_scx[r]);
      cpu_write(ADDR_SCY, row_scy[r]);
      cpu_write(ADDR_BGP, row_bgp[r]);
      cpu_write(ADDR_LYC, row_lyc[r]);
      cpu_write(ADDR_LCDC, row_lcdc[r]);
      // Capture a whole line drawn with the new values
      wait_for_line(row_line[r], 1'b0);
      wait_for_line(row_line[r], 1'b1);
      count  = 0;
      cycles = 0;
      while (line_count == row_line[r] && cycles < int'(DOTS_PER_LINE) + 8) begin
         if (pixel_we) begin
            if (count < int'(SCREEN_WIDTH))
               check_value($sformatf("pixel %0d", count), expected_pixel(r, count),
                           pixel_data);
            count++;
         end
         @(negedge clock);
         cycles++;
      end
      if (line_count == row_line[r])
         report_timeout($sformatf("the end of line %0d", row_line[r]));
      check_value("pixel_we count", SCREEN_WIDTH, count);
      end_test();
   endtask

   task automatic lock_test();
      logic [7:0] data;
      logic [7:0] old_value;
      logic [7:0] new_value;
      begin_test("vram_lock");
      old_value = vram_copy[16'h0123];
      new_value = old_value ^ 8'h5A;
      wait_for_mode(MODE_TRANSFER);
      cpu_write(VRAM_BASE + 16'h0123, new_value);
      cpu_read(VRAM_BASE + 16'h0123, data);
      check_value("read in mode 3", 8'hFF, data);
      wait_for_mode(MODE_VBLANK);
      cpu_read(VRAM_BASE + 16'h0123, data);
      check_value("write in mode 3 dropped", old_value, data);
      cpu_write(VRAM_BASE + 16'h0123, new_value);
      cpu_read(VRAM_BASE + 16'h0123, data);
      check_value("write in V-blank", new_value, data);
      vram_copy[16'h0123] = new_value;
      end_test();
   endtask

   task automatic coincidence_test();
      logic [7:0] data;
      int         cycles;
      begin_test("lyc_match");
      cpu_write(ADDR_LYC, 8'd42);
      // Only the LYC enable
      cpu_write(ADDR_STAT, 8'h40);
      wait_for_line(8'd40, 1'b1);
      acknowledge(1'b0);
      check_value("STAT request after ack", 1'b0, int_lcdc_req);
      cycles = 0;
      while (!int_lcdc_req && cycles < 2 * FRAME_CLOCKS) begin
         @(negedge clock);
         cycles++;
      end
      if (!int_lcdc_req) begin
         report_timeout("int_lcdc_req");
      end else begin
         check_value("LY at STAT request", 8'd42, line_count);
         cpu_read(ADDR_STAT, data);
         check_value("STAT coincidence bit", 1'b1, data[2]);
         acknowledge(1'b0);
      end
      end_test();
   endtask

   ////////////////////
   // Main sequence
   initial begin
      reset          = 1'b1;
      mem_enable     = 1'b0;
      rd_n           = 1'b1;
      wr_n           = 1'b1;
      addr           = 16'h0000;
      wdata          = 8'h00;
      int_vblank_ack = 1'b0;
      int_lcdc_ack   = 1'b0;
      rng_state      = 32'd86238;
      test_errors    = 0;
      total_errors   = 0;
      tests_run      = 0;
      tests_failed   = 0;
      repeat (5) @(posedge clock);
      reset <= 1'b0;
      @(negedge clock);
      register_test();
      preload_vram();
      timing_test();
      sync_test();
      for (int r = 0; r < ROWS; r++)
         pixel_test(r);
      lock_test();
      coincidence_test();
      $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
      if (total_errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

// File: sim.f
rtl/video_pkg.sv
rtl/lcd_registers.sv
rtl/lcd_timing.sv
rtl/video_ram.sv
rtl/bg_fetch_control.sv
rtl/tile_address.sv
rtl/pixel_shade.sv
rtl/video_top.sv
tb/video_tb.sv

// File: Bender.yml
package:
  name: lcd_background

sources:
  - rtl/video_pkg.sv
  - rtl/lcd_registers.sv
  - rtl/lcd_timing.sv
  - rtl/video_ram.sv
  - rtl/bg_fetch_control.sv
  - rtl/tile_address.sv
  - rtl/pixel_shade.sv
  - rtl/video_top.sv
  - target: test
    files:
      - tb/video_tb.sv
